// File: sort_system.f
source/rv_pkg.sv
source/dmem_if.sv
source/inst_mem.sv
source/reg_file.sv
source/decoder.sv
source/alu.sv
source/data_mem.sv
source/sort_cpu.sv
source/sort_system.sv
testbench/sort_system_checker.sv
testbench/sort_system_tb.sv

// File: source/alu.sv
module alu import rv_pkg::*; (
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   input  alu_op_t         op,
   output logic [xlen-1:0] result,
   output logic            taken                   // branch condition
);

   always_comb begin
      result = '0;
      taken  = 1'b0;
      case (op)
         alu_add: result = a + b;                    // also lw / sw address
         alu_sub: result = a - b;
         alu_xor: result = a ^ b;
         alu_eq:  taken  = (a == b);
         alu_ge:  taken  = ($signed(a) >= $signed(b)); // bge is signed
         default: ;
      endcase
   end

endmodule

// File: source/data_mem.sv
module data_mem import rv_pkg::*; #(
   parameter int  dmem_words  = 64,
   localparam int dmem_addr_w = $clog2(dmem_words)
) (
   input  logic                   clk_50,
   dmem_if.mem                    bus,
   input  logic                   host_wen,
   input  logic [dmem_addr_w-1:0] host_addr,
   input  logic [xlen-1:0]        host_wdata,
   input  logic [dmem_addr_w-1:0] host_raddr,
   output logic [xlen-1:0]        host_rdata
);

   logic [xlen-1:0]        mem [dmem_words];
   logic                   wen;
   logic [dmem_addr_w-1:0] waddr;
   logic [xlen-1:0]        wdata;

   // core and host never write together, host is blocked while busy
   assign wen   = bus.wen | host_wen;
   assign waddr = bus.wen ? bus.addr : host_addr;
   assign wdata = bus.wen ? bus.wdata : host_wdata;

   always_ff @(posedge clk_50) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
      if (bus.ren) begin
         bus.rdata <= mem[bus.addr];                 // held until the next lw
      end
      host_rdata <= mem[host_raddr];                 // readback, one cycle
   end

endmodule

// File: source/decoder.sv
module decoder import rv_pkg::*; (
   input  logic [xlen-1:0] instr,
   output logic [4:0]      rs1,
   output logic [4:0]      rs2,
   output logic [4:0]      rd,
   output logic [xlen-1:0] imm,
   output alu_op_t         alu_op,
   output logic            reg_write,
   output logic            is_load,
   output logic            is_store,
   output logic            is_branch
);

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
   assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};                  // halfword aligned offset

   always_comb begin
      imm       = imm_i;
      alu_op    = alu_add;                           // address math for lw / sw
      reg_write = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
      is_branch = 1'b0;
      case (opcode)
         op_imm: begin
            reg_write = (funct3 == f3_add);          // addi only
         end
         op_reg: begin
            if (funct3 == f3_add && funct7 == f7_sub) begin
               alu_op    = alu_sub;
               reg_write = 1'b1;
            end else if (funct3 == f3_add && funct7 == f7_base) begin
               reg_write = 1'b1;
            end else if (funct3 == f3_xor && funct7 == f7_base) begin
               alu_op    = alu_xor;
               reg_write = 1'b1;
            end
         end
         op_load: begin
            is_load   = (funct3 == f3_word);         // lw only, no byte access
            reg_write = (funct3 == f3_word);
         end
         op_store: begin
            imm      = imm_s;
            is_store = (funct3 == f3_word);
         end
         op_branch: begin
            imm       = imm_b;
            alu_op    = (funct3 == f3_bge) ? alu_ge : alu_eq;
            is_branch = (funct3 == f3_beq) || (funct3 == f3_bge);
         end
         default: ;                                  // anything else falls through as nop
      endcase
   end

endmodule

// File: source/dmem_if.sv
interface dmem_if import rv_pkg::*; #(
   parameter int dmem_words = 64
) ();

   localparam int dmem_addr_w = $clog2(dmem_words);

   logic [dmem_addr_w-1:0] addr;                     // word index, wraps
   logic [xlen-1:0]        wdata;
   logic                   wen;                      // write at this edge
   logic                   ren;
   logic [xlen-1:0]        rdata;                    // valid the cycle after ren

   modport core (
      output addr, wdata, wen, ren,
      input  rdata
   );

   modport mem (
      input  addr, wdata, wen, ren,
      output rdata
   );

endinterface

// File: source/inst_mem.sv
module inst_mem import rv_pkg::*; (
   input  logic            clk_50,
   input  logic            rst,
   input  logic [xlen-1:0] addr,                     // byte address from pc
   output logic [xlen-1:0] instr
);

   // bubble sort over ten words at byte 0, one cycle read
   always_ff @(posedge clk_50) begin
      if (rst) begin
         instr <= '0;
      end else begin
         case (addr)
            0:       instr <= 32'h00000013;          // nop
            4:       instr <= 32'h00000013;          // nop
            8:       instr <= 32'h00000013;          // nop
            12:      instr <= 32'h00000013;          // nop
            16:      instr <= 32'h00000013;          // nop
            20:      instr <= 32'hff810113;          // open two stack slots
            24:      instr <= 32'h01412223;          // push s4
            28:      instr <= 32'h01312023;          // push s3
            32:      instr <= 32'h00400993;          // s3 = outer index, starts at 4
            36:      instr <= 32'h00000a13;          // s4 = 0
            40:      instr <= 32'h00000513;          // outer: a0 = array base
            44:      instr <= 32'h02800613;          // a2 = 40, array size in bytes
            48:      instr <= 32'h00050293;          // t0 walks the array
            52:      instr <= 32'h04c9d863;          // outer loop finished -> exit
            56:      instr <= 32'h00000e33;          // clear t3
            60:      instr <= 32'h41360e33;          // t3 = inner bound
            64:      instr <= 32'h000a0f13;          // t5 = inner index
            68:      instr <= 32'h03cf5863;          // inner: bound reached -> next pass
            72:      instr <= 32'h0002a503;          // a0 = arr[j]
            76:      instr <= 32'h0042a583;          // a1 = arr[j+1]
            80:      instr <= 32'h00428293;          // step t0
            84:      instr <= 32'h02a5d463;          // already in order -> skip swap
            88:      instr <= 32'h00050f93;          // swap through t6
            92:      instr <= 32'h00058513;
            96:      instr <= 32'h000f8593;
            100:     instr <= 32'hfea2ae23;          // store lower value
            104:     instr <= 32'h00b2a023;          // store upper value
            108:     instr <= 32'h004f0f13;          // j += 4
            112:     instr <= 32'hfc000ae3;          // back to inner
            116:     instr <= 32'h00498993;          // i += 4
            120:     instr <= 32'hfa0008e3;          // back to outer
            124:     instr <= 32'h004f0f13;          // no swap path, j += 4
            128:     instr <= 32'hfc0002e3;          // back to inner
            132:     instr <= 32'h00012983;          // exit: pop s3
            136:     instr <= 32'h00412a03;          // pop s4
            140:     instr <= 32'h00810113;          // release stack
            144:     instr <= 32'h00a54533;          // clear a0
            default: instr <= halt_word;             // zero word halts the core
         endcase
      end
   end

endmodule

// File: source/reg_file.sv
module reg_file import rv_pkg::*; (
   input  logic            clk_50,
   input  logic            rst,
   input  logic [4:0]      rs1,
   input  logic [4:0]      rs2,
   input  logic [4:0]      rd,
   input  logic            wen,
   input  logic [xlen-1:0] wdata,
   output logic [xlen-1:0] rdata1,
   output logic [xlen-1:0] rdata2
);

   logic [xlen-1:0] regs [32];

   always_ff @(posedge clk_50) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;                           // sp and saved regs start at zero
         end
      end else if (wen && rd != 5'd0) begin        // x0 writes dropped
         regs[rd] <= wdata;
      end
   end

   assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads zero
   assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

   localparam int xlen = 32;                         // machine word width

   // base opcodes of the rv32i subset
   localparam logic [6:0] op_imm    = 7'b0010011;    // addi
   localparam logic [6:0] op_reg    = 7'b0110011;    // add, sub, xor
   localparam logic [6:0] op_load   = 7'b0000011;    // lw
   localparam logic [6:0] op_store  = 7'b0100011;    // sw
   localparam logic [6:0] op_branch = 7'b1100011;    // beq, bge

   localparam logic [2:0] f3_add  = 3'b000;          // add, sub, addi
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_word = 3'b010;          // lw / sw width
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bge  = 3'b101;

   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_sub  = 7'b0100000;      // selects sub over add

   localparam logic [xlen-1:0] halt_word = '0;       // rom default past the program

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_xor,
      alu_eq,                                        // beq compare
      alu_ge                                         // bge compare, signed
   } alu_op_t;

   typedef enum logic [2:0] {
      st_idle,
      st_fetch,
      st_decode,
      st_execute,
      st_mem_wait,                                   // lw only
      st_write_back
   } cpu_state_t;

endpackage

// File: source/sort_cpu.sv
module sort_cpu import rv_pkg::*; #(
   parameter int dmem_words = 64
) (
   input  logic            clk_50,
   input  logic            rst,
   input  logic            start,
   output logic [xlen-1:0] pc,
   input  logic [xlen-1:0] instr,
   output logic            busy,
   output logic            done,
   dmem_if.core            bus
);

   localparam int dmem_addr_w = $clog2(dmem_words);

   cpu_state_t      state;
   logic [xlen-1:0] instr_q;                         // instruction under execution
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [4:0]      rd;
   logic [xlen-1:0] imm;
   alu_op_t         alu_op;
   logic            reg_write;
   logic            is_load;
   logic            is_store;
   logic            is_branch;
   logic [xlen-1:0] rdata1;
   logic [xlen-1:0] rdata2;
   logic [xlen-1:0] alu_b;
   logic [xlen-1:0] alu_result;
   logic            taken;
   logic            use_rs2;
   logic            rf_wen;
   logic [xlen-1:0] rf_wdata;

   decoder dec_i (
      .instr(instr_q), .rs1, .rs2, .rd, .imm, .alu_op,
      .reg_write, .is_load, .is_store, .is_branch
   );

   reg_file rf_i (
      .clk_50, .rst, .rs1, .rs2, .rd,
      .wen(rf_wen), .wdata(rf_wdata), .rdata1, .rdata2
   );

   alu alu_i (.a(rdata1), .b(alu_b), .op(alu_op), .result(alu_result), .taken);

   // operands stay stable from execute to write_back, so no result latch
   assign use_rs2  = is_branch || (instr_q[6:0] == op_reg);
   assign alu_b    = use_rs2 ? rdata2 : imm;
   assign rf_wen   = (state == st_write_back) && reg_write;
   assign rf_wdata = is_load ? bus.rdata : alu_result;
   assign busy     = (state != st_idle);

   assign bus.addr  = alu_result[dmem_addr_w+1:2];  // word index, wraps mod dmem_words
   assign bus.wdata = rdata2;
   assign bus.wen   = (state == st_execute) && is_store;
   assign bus.ren   = (state == st_execute) && is_load;

   always_ff @(posedge clk_50) begin
      if (rst) begin
         state <= st_idle;
         pc    <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            st_idle: begin
               if (start) begin                      // start only seen while idle
                  pc    <= '0;                       // restart from the top
                  state <= st_fetch;
               end
            end
            st_fetch: state <= st_decode;            // rom output lands next cycle
            st_decode: begin
               if (instr == halt_word) begin
                  state <= st_idle;
                  done  <= 1'b1;                     // busy drops with this
               end else begin
                  state <= st_execute;
               end
            end
            st_execute: state <= is_load ? st_mem_wait : st_write_back;
            st_mem_wait: state <= st_write_back;
            st_write_back: begin
               pc    <= (is_branch && taken) ? pc + imm : pc + 32'd4;
               state <= st_fetch;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_50) begin
      if (state == st_decode) begin
         instr_q <= instr;
      end
   end

endmodule

// File: source/sort_system.sv
module sort_system import rv_pkg::*; #(
   parameter int dmem_words = 64
) (
   input  logic            clk_50,
   input  logic            rst,
   input  logic            load_strobe,
   input  logic [xlen-1:0] load_addr,               // byte address
   input  logic [xlen-1:0] load_data,
   input  logic            start,
   input  logic [xlen-1:0] read_addr,               // byte address
   output logic [xlen-1:0] read_data,
   output logic            busy,
   output logic            done
);

   localparam int dmem_addr_w = $clog2(dmem_words);

   logic [xlen-1:0] pc;
   logic [xlen-1:0] instr;

   dmem_if #(.dmem_words(dmem_words)) dmem_bus ();

   sort_cpu #(.dmem_words(dmem_words)) cpu_i (
      .clk_50, .rst, .start, .pc, .instr, .busy, .done,
      .bus(dmem_bus.core)
   );

   inst_mem imem_i (.clk_50, .rst, .addr(pc), .instr);

   data_mem #(.dmem_words(dmem_words)) dmem_i (
      .clk_50,
      .bus(dmem_bus.mem),
      .host_wen(load_strobe & ~busy),                // preload ignored during a run
      .host_addr(load_addr[dmem_addr_w+1:2]),
      .host_wdata(load_data),
      .host_raddr(read_addr[dmem_addr_w+1:2]),
      .host_rdata(read_data)
   );

endmodule

// File: testbench/sort_system_checker.sv
module sort_system_checker (
   input logic clk_50,
   input logic rst,
   input logic busy,
   input logic done
);

   int violations = 0;                               // failed assertions, read at end of run

   done_one_cycle: assert property (@(posedge clk_50) disable iff (rst) done |=> !done)
   else begin
      $error("done held high for more than one cycle");
      violations++;
   end

   done_after_busy: assert property (@(posedge clk_50) disable iff (rst) done |-> $past(busy))
   else begin
      $error("done raised without a run in progress");
      violations++;
   end

   // first cycle out of reset
   idle_after_reset: assert property (@(posedge clk_50) $fell(rst) |-> !busy && !done)
   else begin
      $error("busy or done high right after reset");
      violations++;
   end

   busy_falls_with_done: assert property (@(posedge clk_50) disable iff (rst) $fell(busy) |-> done)
   else begin
      $error("busy dropped without done");
      violations++;
   end

endmodule

bind sort_system sort_system_checker checker_i (.clk_50, .rst, .busy, .done);

// File: testbench/sort_system_tb.sv
module sort_system_tb import rv_pkg::*; ();

   localparam int dmem_words = 64;
   localparam int max_cycles = 5 * 20000;            // five runs, each far below 20000 cycles

   logic            clk_50 = 1'b0;
   logic            rst = 1'b1;
   logic            load_strobe = 1'b0;
   logic [xlen-1:0] load_addr = '0;
   logic [xlen-1:0] load_data = '0;
   logic            start = 1'b0;
   logic [xlen-1:0] read_addr = '0;
   logic [xlen-1:0] read_data;
   logic            busy;
   logic            done;
   int              data [10];                       // array handed to the core
   int              sorted_ref [10];                 // same array, sorted here
   integer          seed = 74721;
   int              errors = 0;
   int              passed = 0;
   int              failed = 0;
   int              cycles = 0;

   sort_system #(.dmem_words(dmem_words)) dut_i (.*);

   always #50 clk_50 = ~clk_50;

   always @(posedge clk_50) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("run timed out after %0d cycles, done never arrived", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic next_cycle();
      @(posedge clk_50);
      #10;                                           // inputs move after the edge
   endtask

   task automatic check_word(input int idx, input int want);
      read_addr = idx * 4;                           // byte address
      next_cycle();
      assert (read_data == want) else begin
         $display("[ERROR] %0t: word %0d reads %0d, expected %0d", $time, idx,
                  $signed(read_data), want);
         errors++;
      end
   endtask

   // insertion sort, signed ascending
   task automatic sort_expected();
      int key;
      int j;
      sorted_ref = data;
      for (int i = 1; i < 10; i++) begin
         key = sorted_ref[i];
         j = i - 1;
         while (j >= 0 && sorted_ref[j] > key) begin
            sorted_ref[j+1] = sorted_ref[j];
            j--;
         end
         sorted_ref[j+1] = key;
      end
   endtask

   task automatic run_sort(input bit preload, input bit disturb);
      for (int i = 0; i < 10 && preload; i++) begin
         load_strobe = 1'b1;
         load_addr   = i * 4;
         load_data   = data[i];
         next_cycle();
      end
      load_strobe = 1'b0;
      start = 1'b1;
      next_cycle();
      start = 1'b0;
      if (disturb) begin
         repeat (30) next_cycle();                   // well inside the run
         assert (busy) else begin
            $display("[ERROR] %0t: core idle before the host actions", $time);
            errors++;
         end
         load_strobe = 1'b1;                         // overwrite attempt on word 0
         load_addr   = '0;
         load_data   = 32'h7fff_0000;
         start       = 1'b1;                         // extra start mid run
         next_cycle();
         load_strobe = 1'b0;
         start       = 1'b0;
      end
      while (!done) next_cycle();
      for (int i = 0; i < 10; i++) check_word(i, sorted_ref[i]);
   endtask

   task automatic report(input string name, input int mark);
      if (errors == mark) begin
         passed++;
         $display("%s: pass", name);
      end else begin
         failed++;
         $display("%s: fail with %0d mismatches", name, errors - mark);
      end
   endtask

   initial begin
      int mark;
      repeat (10) next_cycle();                      // reset held 10 cycles
      rst = 1'b0;

      mark = errors;
      repeat (5) begin
         next_cycle();
         assert (!busy && !done) else begin
            $display("[ERROR] %0t: busy or done high before any start", $time);
            errors++;
         end
      end
      report("reset state", mark);

      mark = errors;
      for (int i = 0; i < 10; i++) data[i] = 10 - i;
      sort_expected();
      run_sort(1'b1, 1'b0);
      report("reversed input", mark);

      mark = errors;
      for (int i = 0; i < 10; i++) data[i] = $random(seed) % 1000;
      data[5] = -750;                                // at least one negative
      data[7] = data[2];                             // one equal pair
      sort_expected();
      run_sort(1'b1, 1'b0);
      report("random signed", mark);

      mark = errors;
      for (int i = 0; i < 10; i++) data[i] = i * 3 - 12;
      sort_expected();
      run_sort(1'b1, 1'b0);
      run_sort(1'b0, 1'b0);                          // restart on the array left in memory
      report("sorted, then restarted", mark);

      mark = errors;
      for (int i = 0; i < 10; i++) data[i] = (i * 7) % 10 - 5;
      sort_expected();
      run_sort(1'b1, 1'b1);
      report("host actions while busy", mark);

      mark = errors;
      check_word(dmem_words - 2, 0);                 // saved s3 slot
      check_word(dmem_words - 1, 0);                 // saved s4 slot
      report("stack words restored", mark);

      $display("tests passed %0d, failed %0d, protocol violations %0d", passed, failed,
               dut_i.checker_i.violations);
      if (failed == 0 && dut_i.checker_i.violations == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
